//--- rtl/fftPkg.sv
package fftPkg;

    //////////////////////////////////////////////////
    // transform sizes
    //////////////////////////////////////////////////

    localparam int pointCount   = 8;
    localparam int addrWidth    = 3;
    localparam int stageCount   = 3;
    localparam int sampleWidth  = 18;
    localparam int twiddleWidth = 16;

    typedef logic signed [sampleWidth-1:0] sample_t;
    // Q1.14 twiddle factor
    typedef logic signed [twiddleWidth-1:0] twiddle_t;

    // W8^k for k = 0..3
    localparam twiddle_t twiddleCos [4] = '{16'sd16384, 16'sd11585, 16'sd0, -16'sd11585};
    localparam twiddle_t twiddleSin [4] = '{16'sd0, -16'sd11585, -16'sd16384, -16'sd11585};

    //////////////////////////////////////////////////
    // state and direction encodings
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE, LOADI, LOADF, STARTF, STARTI, CALCULATINGF, CALCULATINGI, DONE
    } ctrlState_t;

    // butterfly sequencing states
    typedef enum logic [1:0] {
        ENG_IDLE, ENG_READ, ENG_COMPUTE, ENG_WRITE
    } engineState_t;

    typedef enum logic {
        FORWARD, INVERSE
    } direction_t;

endpackage

//--- rtl/fftControl.sv
module fftControl import fftPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic startF,
    input  logic startI,
    input  logic loadExternalDone,
    input  logic done,
    output logic calculating,
    output logic loadExternal,
    output logic loadInternal,
    output logic isIFFT,
    output logic startFFT,
    output logic aDone
);

    ctrlState_t state;
    ctrlState_t nextState;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    //////////////////////////////////////////////////
    // next state and Moore outputs
    //////////////////////////////////////////////////

    always_comb begin
        nextState    = state;
        calculating  = 1'b0;
        loadExternal = 1'b0;
        loadInternal = 1'b0;
        isIFFT       = 1'b0;
        startFFT     = 1'b0;
        aDone        = 1'b0;

        case (state)
            IDLE: begin
                // forward has priority when both starts arrive
                if (startF) begin
                    nextState = LOADF;
                end else if (startI) begin
                    nextState = LOADI;
                end
            end
            // wait for the eight samples
            LOADF, LOADI: begin
                loadExternal = 1'b1;
                calculating  = 1'b1;
                isIFFT       = (state == LOADI);
                if (loadExternalDone) begin
                    nextState = (state == LOADI) ? STARTI : STARTF;
                end
            end
            STARTF, STARTI: begin
                startFFT    = 1'b1;
                calculating = 1'b1;
                isIFFT      = (state == STARTI);
                nextState   = (state == STARTI) ? CALCULATINGI : CALCULATINGF;
            end
            // engine owns the buffer here
            CALCULATINGF, CALCULATINGI: begin
                calculating  = 1'b1;
                loadInternal = 1'b1;
                isIFFT       = (state == CALCULATINGI);
                if (done) begin
                    nextState = DONE;
                end
            end
            DONE: begin
                aDone     = 1'b1;
                nextState = IDLE;
            end
            default: nextState = IDLE;
        endcase
    end

endmodule

//--- rtl/sampleBuffer.sv
module sampleBuffer import fftPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 loadExternal,
    input  logic                 sampleValid,
    input  sample_t              sampleRe,
    input  sample_t              sampleIm,
    output logic                 loadExternalDone,
    input  logic                 loadInternal,
    input  logic                 engRead,
    input  logic [addrWidth-1:0] engAddrA,
    input  logic [addrWidth-1:0] engAddrB,
    input  logic                 engWrite,
    input  sample_t              engWrARe,
    input  sample_t              engWrAIm,
    input  sample_t              engWrBRe,
    input  sample_t              engWrBIm,
    output sample_t              engRdARe,
    output sample_t              engRdAIm,
    output sample_t              engRdBRe,
    output sample_t              engRdBIm,
    input  logic [addrWidth-1:0] readAddr,
    output sample_t              readRe,
    output sample_t              readIm
);

    sample_t              memRe [pointCount];
    sample_t              memIm [pointCount];
    logic [addrWidth-1:0] loadCount;
    logic [addrWidth-1:0] loadAddr;

    // samples land in bit-reversed order for the in-place DIT engine
    always_comb begin
        for (int i = 0; i < addrWidth; i++) begin
            loadAddr[i] = loadCount[addrWidth-1-i];
        end
    end

    assign loadExternalDone = loadExternal && sampleValid
                              && (loadCount == addrWidth'(pointCount - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            loadCount <= '0;
        end else if (!loadExternal) begin
            loadCount <= '0;
        end else if (sampleValid) begin
            loadCount <= loadCount + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (loadExternal && sampleValid) begin
            memRe[loadAddr] <= sampleRe;
            memIm[loadAddr] <= sampleIm;
        end else if (loadInternal && engWrite) begin
            memRe[engAddrA] <= engWrARe;
            memIm[engAddrA] <= engWrAIm;
            memRe[engAddrB] <= engWrBRe;
            memIm[engAddrB] <= engWrBIm;
        end
        if (loadInternal && engRead) begin
            engRdARe <= memRe[engAddrA];
            engRdAIm <= memIm[engAddrA];
            engRdBRe <= memRe[engAddrB];
            engRdBIm <= memIm[engAddrB];
        end
        // read-out port only when the engine is not using the RAM
        if (!loadInternal) begin
            readRe <= memRe[readAddr];
            readIm <= memIm[readAddr];
        end
    end

endmodule

//--- rtl/butterflyUnit.sv
module butterflyUnit import fftPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       bfValid,
    input  logic       isIFFT,
    input  logic [1:0] twiddleIndex,
    input  sample_t    inARe,
    input  sample_t    inAIm,
    input  sample_t    inBRe,
    input  sample_t    inBIm,
    output sample_t    outARe,
    output sample_t    outAIm,
    output sample_t    outBRe,
    output sample_t    outBIm
);

    localparam int fracBits = twiddleWidth - 2;

    twiddle_t                                wRe;
    twiddle_t                                wIm;
    logic signed [sampleWidth+twiddleWidth:0] prodRe;
    logic signed [sampleWidth+twiddleWidth:0] prodIm;
    logic signed [sampleWidth+2:0]            tRe;
    logic signed [sampleWidth+2:0]            tIm;
    logic signed [sampleWidth+3:0]            sumRe;
    logic signed [sampleWidth+3:0]            sumIm;
    logic signed [sampleWidth+3:0]            difRe;
    logic signed [sampleWidth+3:0]            difIm;

    always_comb begin
        wRe = twiddleCos[twiddleIndex];
        // inverse uses the conjugate twiddle
        wIm = isIFFT ? -twiddleSin[twiddleIndex] : twiddleSin[twiddleIndex];

        prodRe = inBRe * wRe - inBIm * wIm;
        prodIm = inBRe * wIm + inBIm * wRe;
        // upper bits give the floor shift by 14
        tRe = prodRe[sampleWidth+twiddleWidth:fracBits];
        tIm = prodIm[sampleWidth+twiddleWidth:fracBits];

        sumRe = inARe + tRe;
        sumIm = inAIm + tIm;
        difRe = inARe - tRe;
        difIm = inAIm - tIm;
    end

    // halve each part on the way into the output register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outARe <= '0;
            outAIm <= '0;
            outBRe <= '0;
            outBIm <= '0;
        end else if (bfValid) begin
            outARe <= sumRe[sampleWidth:1];
            outAIm <= sumIm[sampleWidth:1];
            outBRe <= difRe[sampleWidth:1];
            outBIm <= difIm[sampleWidth:1];
        end
    end

endmodule

//--- rtl/fftEngine.sv
module fftEngine import fftPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 startFFT,
    input  logic                 isIFFT,
    output logic                 done,
    output logic                 engRead,
    output logic [addrWidth-1:0] engAddrA,
    output logic [addrWidth-1:0] engAddrB,
    output logic                 engWrite,
    output sample_t              engWrARe,
    output sample_t              engWrAIm,
    output sample_t              engWrBRe,
    output sample_t              engWrBIm,
    input  sample_t              engRdARe,
    input  sample_t              engRdAIm,
    input  sample_t              engRdBRe,
    input  sample_t              engRdBIm,
    output logic                 bfValid,
    output logic                 bfIsIFFT,
    output logic [1:0]           twiddleIndex,
    output sample_t              bfInARe,
    output sample_t              bfInAIm,
    output sample_t              bfInBRe,
    output sample_t              bfInBIm,
    input  sample_t              bfOutARe,
    input  sample_t              bfOutAIm,
    input  sample_t              bfOutBRe,
    input  sample_t              bfOutBIm
);

    localparam logic [1:0]           lastStage = 2'(stageCount - 1);
    localparam logic [addrWidth-2:0] lastBfly  = (addrWidth-1)'(pointCount / 2 - 1);

    engineState_t         state;
    direction_t           runDir;
    logic [1:0]           stage;
    logic [addrWidth-2:0] bfly;
    logic                 lastBflyOfRun;

    assign lastBflyOfRun = (stage == lastStage) && (bfly == lastBfly);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= ENG_IDLE;
            runDir <= FORWARD;
            stage  <= '0;
            bfly   <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ENG_IDLE: begin
                    if (startFFT) begin
                        runDir <= isIFFT ? INVERSE : FORWARD;
                        stage  <= '0;
                        bfly   <= '0;
                        state  <= ENG_READ;
                    end
                end
                ENG_READ:    state <= ENG_COMPUTE;
                ENG_COMPUTE: state <= ENG_WRITE;
                ENG_WRITE: begin
                    if (lastBflyOfRun) begin
                        done  <= 1'b1;
                        state <= ENG_IDLE;
                    end else begin
                        // next butterfly, or first one of the next stage
                        bfly  <= bfly + 1'b1;
                        stage <= (bfly == lastBfly) ? stage + 1'b1 : stage;
                        state <= ENG_READ;
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // pair addresses and twiddle index
    //////////////////////////////////////////////////

    // half-span is 1, 2, 4 for stages 0, 1, 2
    always_comb begin
        case (stage)
            2'd0: begin
                engAddrA     = {bfly, 1'b0};
                twiddleIndex = 2'd0;
            end
            2'd1: begin
                engAddrA     = {bfly[1], 1'b0, bfly[0]};
                twiddleIndex = {bfly[0], 1'b0};
            end
            default: begin
                engAddrA     = {1'b0, bfly};
                twiddleIndex = bfly;
            end
        endcase
        engAddrB = engAddrA | (addrWidth'(1) << stage);
    end

    assign engRead  = (state == ENG_READ);
    assign bfValid  = (state == ENG_COMPUTE);
    assign engWrite = (state == ENG_WRITE);
    assign bfIsIFFT = (runDir == INVERSE);

    // operands straight from the RAM, results straight back
    assign bfInARe  = engRdARe;
    assign bfInAIm  = engRdAIm;
    assign bfInBRe  = engRdBRe;
    assign bfInBIm  = engRdBIm;
    assign engWrARe = bfOutARe;
    assign engWrAIm = bfOutAIm;
    assign engWrBRe = bfOutBRe;
    assign engWrBIm = bfOutBIm;

endmodule

//--- rtl/fftTop.sv
module fftTop import fftPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 startF,
    input  logic                 startI,
    input  logic                 sampleValid,
    input  sample_t              sampleRe,
    input  sample_t              sampleIm,
    input  logic [addrWidth-1:0] readAddr,
    output logic                 loadExternal,
    output logic                 calculating,
    output logic                 isIFFT,
    output logic                 aDone,
    output sample_t              readRe,
    output sample_t              readIm
);

    logic                 loadExternalDone;
    logic                 loadInternal;
    logic                 startFFT;
    logic                 done;
    logic                 engRead;
    logic                 engWrite;
    logic [addrWidth-1:0] engAddrA;
    logic [addrWidth-1:0] engAddrB;
    sample_t              engWrARe, engWrAIm, engWrBRe, engWrBIm;
    sample_t              engRdARe, engRdAIm, engRdBRe, engRdBIm;
    logic                 bfValid;
    logic                 bfIsIFFT;
    logic [1:0]           twiddleIndex;
    sample_t              bfInARe, bfInAIm, bfInBRe, bfInBIm;
    sample_t              bfOutARe, bfOutAIm, bfOutBRe, bfOutBIm;

    fftControl control (
        .clk, .rst, .startF, .startI, .loadExternalDone, .done,
        .calculating, .loadExternal, .loadInternal, .isIFFT, .startFFT, .aDone
    );

    sampleBuffer buffer (
        .clk, .rst, .loadExternal, .sampleValid, .sampleRe, .sampleIm, .loadExternalDone,
        .loadInternal, .engRead, .engAddrA, .engAddrB, .engWrite,
        .engWrARe, .engWrAIm, .engWrBRe, .engWrBIm,
        .engRdARe, .engRdAIm, .engRdBRe, .engRdBIm,
        .readAddr, .readRe, .readIm
    );

    fftEngine engine (
        .clk, .rst, .startFFT, .isIFFT, .done,
        .engRead, .engAddrA, .engAddrB, .engWrite,
        .engWrARe, .engWrAIm, .engWrBRe, .engWrBIm,
        .engRdARe, .engRdAIm, .engRdBRe, .engRdBIm,
        .bfValid, .bfIsIFFT, .twiddleIndex,
        .bfInARe, .bfInAIm, .bfInBRe, .bfInBIm,
        .bfOutARe, .bfOutAIm, .bfOutBRe, .bfOutBIm
    );

    butterflyUnit butterfly (
        .clk, .rst, .bfValid, .isIFFT(bfIsIFFT), .twiddleIndex,
        .inARe(bfInARe), .inAIm(bfInAIm), .inBRe(bfInBRe), .inBIm(bfInBIm),
        .outARe(bfOutARe), .outAIm(bfOutAIm), .outBRe(bfOutBRe), .outBIm(bfOutBIm)
    );

endmodule

//--- verification/fftTb.sv
module fftTb import fftPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int transformCount = 40;
    localparam int maxCycles      = 120;
    localparam int clkPeriod      = 40;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 startF;
    logic                 startI;
    logic                 sampleValid;
    sample_t              sampleRe;
    sample_t              sampleIm;
    logic [addrWidth-1:0] readAddr;
    logic                 loadExternal;
    logic                 calculating;
    logic                 isIFFT;
    logic                 aDone;
    sample_t              readRe;
    sample_t              readIm;

    logic [31:0] rngState;
    longint      inRe  [pointCount];
    longint      inIm  [pointCount];
    longint      expRe [pointCount];
    longint      expIm [pointCount];

    fftTop i_dut (
        .clk, .rst, .startF, .startI, .sampleValid, .sampleRe, .sampleIm, .readAddr,
        .loadExternal, .calculating, .isIFFT, .aDone, .readRe, .readIm
    );

    always #(clkPeriod / 2) clk = ~clk;

    // watchdog over all transforms plus margin
    initial begin
        #((transformCount * maxCycles + 200) * clkPeriod);
        $display("timeout: the transforms did not finish in time");
        $display("Test FAILED");
        $fatal(1);
    end

    //////////////////////////////////////////////////
    // random numbers and compare tasks
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function int unsigned randBelow(input int unsigned n);
        rngState = xorshift(rngState);
        return rngState % n;
    endfunction

    // uniform in -2^16 .. 2^16
    function longint randSample();
        return longint'(randBelow(131073)) - 65536;
    endfunction

    task automatic checkSample(input string name, input sample_t expected, input sample_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %0b, actual %0b", name, expected, actual);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // bit reversal, then three radix-2 stages with floor rounding and halving
    task automatic runModel(input bit inverse);
        longint re [pointCount];
        longint im [pointCount];
        longint wr, wi, tr, ti, ar, ai;
        int     half, a, b, rev, tw;
        for (int i = 0; i < pointCount; i++) begin
            rev = ((i & 1) << 2) | (i & 2) | ((i >> 2) & 1);
            re[rev] = inRe[i];
            im[rev] = inIm[i];
        end
        for (int s = 0; s < stageCount; s++) begin
            half = 1 << s;
            for (int g = 0; g < pointCount; g += 2 * half) begin
                for (int k = 0; k < half; k++) begin
                    a  = g + k;
                    b  = a + half;
                    tw = k * (pointCount / (2 * half));
                    wr = longint'(twiddleCos[tw]);
                    wi = longint'(twiddleSin[tw]);
                    if (inverse) begin
                        wi = -wi;
                    end
                    tr = (re[b] * wr - im[b] * wi) >>> 14;
                    ti = (re[b] * wi + im[b] * wr) >>> 14;
                    ar = re[a];
                    ai = im[a];
                    re[a] = (ar + tr) >>> 1;
                    im[a] = (ai + ti) >>> 1;
                    re[b] = (ar - tr) >>> 1;
                    im[b] = (ai - ti) >>> 1;
                end
            end
        end
        for (int i = 0; i < pointCount; i++) begin
            expRe[i] = re[i];
            expIm[i] = im[i];
        end
    endtask

    //////////////////////////////////////////////////
    // one transform: start, load, wait, read out
    //////////////////////////////////////////////////

    task automatic runTransform(input int idx, input bit inverse, input bit bothStarts,
                                input bit strays);
        string tag;
        int    gap;
        tag = $sformatf("%s%0d", inverse ? "ifft" : "fft", idx);
        for (int i = 0; i < pointCount; i++) begin
            inRe[i] = randSample();
            inIm[i] = randSample();
        end
        runModel(inverse);

        @(negedge clk);
        startF = !inverse || bothStarts;
        startI = inverse || bothStarts;
        @(negedge clk);
        startF = 1'b0;
        startI = 1'b0;
        checkFlag({tag, " loadExternal"}, 1'b1, loadExternal);
        checkFlag({tag, " isIFFT load"}, inverse, isIFFT);

        // samples with random gaps and stray starts inside the gaps
        for (int i = 0; i < pointCount; i++) begin
            gap = randBelow(3);
            repeat (gap) begin
                sampleValid = 1'b0;
                if (strays) begin
                    startF = (randBelow(2) == 0);
                    startI = (randBelow(2) == 0);
                end
                @(negedge clk);
            end
            startF      = 1'b0;
            startI      = 1'b0;
            sampleValid = 1'b1;
            sampleRe    = sample_t'(inRe[i]);
            sampleIm    = sample_t'(inIm[i]);
            @(negedge clk);
        end
        sampleValid = 1'b0;

        while (!aDone) begin
            checkFlag({tag, " calculating"}, 1'b1, calculating);
            checkFlag({tag, " loadExternal calc"}, 1'b0, loadExternal);
            checkFlag({tag, " isIFFT calc"}, inverse, isIFFT);
            if (strays) begin
                sampleValid = (randBelow(4) == 0);
                sampleRe    = sample_t'(randSample());
                sampleIm    = sample_t'(randSample());
                startF      = (randBelow(4) == 0);
                startI      = (randBelow(4) == 0);
            end
            @(negedge clk);
        end
        sampleValid = 1'b0;
        startF      = 1'b0;
        startI      = 1'b0;
        checkFlag({tag, " calculating at aDone"}, 1'b0, calculating);
        @(negedge clk);
        checkFlag({tag, " aDone width"}, 1'b0, aDone);

        // address 0 comes last so that a stray idle write to it would show
        for (int a = pointCount - 1; a >= 0; a--) begin
            readAddr = addrWidth'(a);
            // stray valids while idle write nothing
            if (strays) begin
                sampleValid = (randBelow(2) == 0);
            end
            @(negedge clk);
            checkSample($sformatf("%s re[%0d]", tag, a), sample_t'(expRe[a]), readRe);
            checkSample($sformatf("%s im[%0d]", tag, a), sample_t'(expIm[a]), readIm);
            checkFlag({tag, " calculating idle"}, 1'b0, calculating);
            checkFlag({tag, " isIFFT idle"}, 1'b0, isIFFT);
        end
        sampleValid = 1'b0;
    endtask

    initial begin
        rst         = 1'b1;
        startF      = 1'b0;
        startI      = 1'b0;
        sampleValid = 1'b0;
        sampleRe    = '0;
        sampleIm    = '0;
        readAddr    = '0;
        rngState    = 32'd21;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        checkFlag("reset loadExternal", 1'b0, loadExternal);
        checkFlag("reset calculating", 1'b0, calculating);
        checkFlag("reset isIFFT", 1'b0, isIFFT);
        checkFlag("reset aDone", 1'b0, aDone);

        // odd runs are inverse and some even runs raise both starts
        for (int n = 0; n < transformCount; n++) begin
            runTransform(n, (n % 2) == 1, (n % 8) == 4, (n % 3) == 0);
        end

        $display("Test OK");
        $finish;
    end

endmodule

//--- filelist.f
rtl/fftPkg.sv
rtl/fftControl.sv
rtl/sampleBuffer.sv
rtl/butterflyUnit.sv
rtl/fftEngine.sv
rtl/fftTop.sv
verification/fftTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
# build the simulation binary from the file list
verilator --binary --timing -Wno-fatal -f filelist.f --top-module fftTb -o fftSim
# a $fatal in the testbench gives a non-zero exit status
./obj_dir/fftSim
